/* rtl/arith_rs_cfg.svh */
// Reservation station configuration

`ifndef ARITH_RS_CFG_SVH_
`define ARITH_RS_CFG_SVH_

`default_nettype none

// Number of station entries, power of two
`define ARITH_RS_DEPTH 4

// Datapath word width
`define XLEN 64

// ROB entry index width
`define ROB_IDX_LEN 4

// EU operation code width
`define EU_CTL_LEN 4

`default_nettype wire

`endif

/* rtl/expipe_pkg.sv */
// Execution pipeline bus types

`include "arith_rs_cfg.svh"
`default_nettype none

package expipe_pkg;

  typedef logic [`XLEN-1:0]        word_t;
  typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t;
  typedef logic [`EU_CTL_LEN-1:0]  eu_ctl_t;

  // Source operand, value valid only when ready is set
  typedef struct packed {
    logic     ready;
    rob_idx_t rob_idx;  // Producer ROB entry when pending
    word_t    value;
  } op_data_t;

  typedef struct packed {
    eu_ctl_t  eu_ctl;
    op_data_t rs1;
    op_data_t rs2;
    rob_idx_t dest_rob_idx;
  } issue_req_t;

  typedef struct packed {
    eu_ctl_t  eu_ctl;
    word_t    rs1_value;
    word_t    rs2_value;
    rob_idx_t rob_idx;  // Tag returned with the result
  } eu_req_t;

  typedef struct packed {
    rob_idx_t rob_idx;
    word_t    result;
  } eu_res_t;

  typedef struct packed {
    rob_idx_t rob_idx;
    word_t    res_value;
  } cdb_data_t;

endpackage

`default_nettype wire

/* rtl/arith_rs_pkg.sv */
// Reservation station internal types

`include "arith_rs_cfg.svh"
`default_nettype none

package arith_rs_pkg;

  import expipe_pkg::*;

  typedef logic [$clog2(`ARITH_RS_DEPTH)-1:0] rs_idx_t;

  typedef enum logic [2:0] {
    EMPTY,
    RS1_PENDING,   // Waiting for rs1 only
    RS2_PENDING,   // Waiting for rs2 only
    RS12_PENDING,  // Waiting for both operands
    EX_REQ,        // Requesting the EU
    EX_WAIT,       // Issued, result not back yet
    COMPLETED      // Result waits for the CDB
  } rs_state_t;

  typedef struct packed {
    eu_ctl_t  eu_ctl;
    rob_idx_t rs1_rob_idx;
    word_t    rs1_value;
    rob_idx_t rs2_rob_idx;
    word_t    rs2_value;
    rob_idx_t dest_rob_idx;
    word_t    res_value;
  } rs_entry_t;

endpackage

`default_nettype wire

/* rtl/arith_rs_entry.sv */
// Reservation station entry

`timescale 1ns/1ps
`default_nettype none

module arith_rs_entry (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,

  // Strobes from the selector
  input  logic                    insert_i,
  input  logic                    ex_grant_i,
  input  logic                    cdb_grant_i,

  // Broadcast buses
  input  expipe_pkg::issue_req_t  issue_req_i,
  input  logic                    eu_valid_i,
  input  expipe_pkg::eu_res_t     eu_res_i,
  input  logic                    cdb_valid_i,
  input  expipe_pkg::cdb_data_t   cdb_data_i,

  // Status towards the selector
  output logic                    empty_o,
  output logic                    ex_req_o,
  output logic                    cdb_req_o,
  output arith_rs_pkg::rs_entry_t entry_o
);

  import expipe_pkg::*;
  import arith_rs_pkg::*;

  rs_state_t state_q, state_d;
  rs_entry_t data_q, data_d;

  rob_idx_t rs1_idx;
  rob_idx_t rs2_idx;
  logic     rs1_eu_hit, rs2_eu_hit;
  logic     rs1_cdb_hit, rs2_cdb_hit;
  logic     rs1_fwd, rs2_fwd;
  word_t    rs1_fwd_value, rs2_fwd_value;
  logic     rs1_avail, rs2_avail;  // Operand present at insertion
  logic     res_hit;

  // Where an entry goes once it knows which operands it holds
  function automatic rs_state_t operand_state(input logic have_rs1, input logic have_rs2);
    rs_state_t st;
    unique case ({have_rs1, have_rs2})
      2'b11:   st = EX_REQ;
      2'b10:   st = RS2_PENDING;
      2'b01:   st = RS1_PENDING;
      default: st = RS12_PENDING;
    endcase
    return st;
  endfunction

  // ------------------------------------------------
  // Operand forwarding
  // ------------------------------------------------

  // Incoming tags while inserting, stored ones afterwards
  assign rs1_idx = insert_i ? issue_req_i.rs1.rob_idx : data_q.rs1_rob_idx;
  assign rs2_idx = insert_i ? issue_req_i.rs2.rob_idx : data_q.rs2_rob_idx;

  assign rs1_eu_hit  = eu_valid_i & (eu_res_i.rob_idx == rs1_idx);
  assign rs2_eu_hit  = eu_valid_i & (eu_res_i.rob_idx == rs2_idx);
  assign rs1_cdb_hit = cdb_valid_i & (cdb_data_i.rob_idx == rs1_idx);
  assign rs2_cdb_hit = cdb_valid_i & (cdb_data_i.rob_idx == rs2_idx);

  assign rs1_fwd = rs1_eu_hit | rs1_cdb_hit;
  assign rs2_fwd = rs2_eu_hit | rs2_cdb_hit;

  // EU result wins over the CDB
  assign rs1_fwd_value = rs1_eu_hit ? eu_res_i.result : cdb_data_i.res_value;
  assign rs2_fwd_value = rs2_eu_hit ? eu_res_i.result : cdb_data_i.res_value;

  assign rs1_avail = issue_req_i.rs1.ready | rs1_fwd;
  assign rs2_avail = issue_req_i.rs2.ready | rs2_fwd;

  // Own result on the EU bus
  assign res_hit = eu_valid_i & (eu_res_i.rob_idx == data_q.dest_rob_idx);

  // ------------------------------------------------
  // Entry state machine
  // ------------------------------------------------

  // Mealy, data is captured in the same cycle as the transition
  always_comb begin : p_fsm
    state_d = state_q;
    data_d  = data_q;
    unique case (state_q)
      EMPTY: begin
        if (insert_i) begin
          data_d.eu_ctl       = issue_req_i.eu_ctl;
          data_d.rs1_rob_idx  = issue_req_i.rs1.rob_idx;
          data_d.rs2_rob_idx  = issue_req_i.rs2.rob_idx;
          data_d.dest_rob_idx = issue_req_i.dest_rob_idx;
          data_d.rs1_value    = issue_req_i.rs1.ready ? issue_req_i.rs1.value : rs1_fwd_value;
          data_d.rs2_value    = issue_req_i.rs2.ready ? issue_req_i.rs2.value : rs2_fwd_value;
          state_d             = operand_state(rs1_avail, rs2_avail);
        end
      end
      RS12_PENDING: begin
        if (rs1_fwd) data_d.rs1_value = rs1_fwd_value;
        if (rs2_fwd) data_d.rs2_value = rs2_fwd_value;
        state_d = operand_state(rs1_fwd, rs2_fwd);
      end
      RS1_PENDING: begin
        if (rs1_fwd) begin
          data_d.rs1_value = rs1_fwd_value;
          state_d          = EX_REQ;
        end
      end
      RS2_PENDING: begin
        if (rs2_fwd) begin
          data_d.rs2_value = rs2_fwd_value;
          state_d          = EX_REQ;
        end
      end
      EX_REQ: begin
        if (res_hit) begin  // Result may beat the grant
          data_d.res_value = eu_res_i.result;
          state_d          = COMPLETED;
        end else if (ex_grant_i) begin
          state_d = EX_WAIT;
        end
      end
      EX_WAIT: begin
        if (res_hit) begin
          data_d.res_value = eu_res_i.result;
          state_d          = COMPLETED;
        end
      end
      COMPLETED: begin
        if (cdb_grant_i) state_d = EMPTY;
      end
      default: state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= EMPTY;
    end else if (flush_i) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    data_q <= data_d;
  end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  assign empty_o   = (state_q == EMPTY);
  assign ex_req_o  = (state_q == EX_REQ);
  assign cdb_req_o = (state_q == COMPLETED);
  assign entry_o   = data_q;

endmodule

`default_nettype wire

/* rtl/arith_rs_select.sv */
// Reservation station entry selection

`timescale 1ns/1ps
`include "arith_rs_cfg.svh"
`default_nettype none

module arith_rs_select (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,

  // Issue side
  input  logic                                         issue_valid_i,
  output logic                                         issue_ready_o,

  // Entry status
  input  logic                    [`ARITH_RS_DEPTH-1:0] empty_i,
  input  logic                    [`ARITH_RS_DEPTH-1:0] ex_req_i,
  input  logic                    [`ARITH_RS_DEPTH-1:0] cdb_req_i,
  input  arith_rs_pkg::rs_entry_t [`ARITH_RS_DEPTH-1:0] entries_i,

  // Execution unit
  input  logic                                         eu_ready_i,
  output logic                                         eu_valid_o,
  output expipe_pkg::eu_req_t                          eu_req_o,

  // CDB write
  input  logic                                         cdb_ready_i,
  output logic                                         cdb_valid_o,
  output expipe_pkg::cdb_data_t                        cdb_data_o,

  // One-hot strobes to the entries
  output logic                    [`ARITH_RS_DEPTH-1:0] insert_o,
  output logic                    [`ARITH_RS_DEPTH-1:0] ex_grant_o,
  output logic                    [`ARITH_RS_DEPTH-1:0] cdb_grant_o
);

  import arith_rs_pkg::*;

  rs_idx_t new_idx_q;  // Insertion pointer
  rs_idx_t ex_idx;
  rs_idx_t cdb_idx;
  logic    insert;
  logic    ex_accept;
  logic    cdb_accept;

  // Lowest set line wins
  function automatic rs_idx_t lowest_set(input logic [`ARITH_RS_DEPTH-1:0] lines);
    rs_idx_t idx;
    idx = '0;
    for (int i = `ARITH_RS_DEPTH - 1; i >= 0; i--) begin
      if (lines[i]) idx = rs_idx_t'(i);
    end
    return idx;
  endfunction

  // ------------------------------------------------
  // Insertion pointer
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_new_idx
    if (!rst_ni) begin
      new_idx_q <= '0;
    end else if (flush_i) begin
      new_idx_q <= '0;
    end else if (insert) begin
      new_idx_q <= new_idx_q + rs_idx_t'(1);  // Wraps, depth is a power of two
    end
  end

  assign issue_ready_o = empty_i[new_idx_q];
  assign insert        = issue_valid_i & issue_ready_o;

  // ------------------------------------------------
  // Execute and CDB choice
  // ------------------------------------------------
  assign ex_idx     = lowest_set(ex_req_i);
  assign eu_valid_o = |ex_req_i;
  assign ex_accept  = eu_valid_o & eu_ready_i;

  assign eu_req_o.eu_ctl    = entries_i[ex_idx].eu_ctl;
  assign eu_req_o.rs1_value = entries_i[ex_idx].rs1_value;
  assign eu_req_o.rs2_value = entries_i[ex_idx].rs2_value;
  assign eu_req_o.rob_idx   = entries_i[ex_idx].dest_rob_idx;

  assign cdb_idx     = lowest_set(cdb_req_i);
  assign cdb_valid_o = |cdb_req_i;
  assign cdb_accept  = cdb_valid_o & cdb_ready_i;

  assign cdb_data_o.rob_idx   = entries_i[cdb_idx].dest_rob_idx;
  assign cdb_data_o.res_value = entries_i[cdb_idx].res_value;

  // Strobes only on accepted transfers
  always_comb begin : p_strobes
    insert_o              = '0;
    ex_grant_o            = '0;
    cdb_grant_o           = '0;
    insert_o[new_idx_q]   = insert;
    ex_grant_o[ex_idx]    = ex_accept;
    cdb_grant_o[cdb_idx]  = cdb_accept;
  end

endmodule

`default_nettype wire

/* rtl/arith_rs.sv */
// Arithmetic reservation station

`timescale 1ns/1ps
`include "arith_rs_cfg.svh"
`default_nettype none

module arith_rs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,

  // Issue stage
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  input  expipe_pkg::issue_req_t issue_req_i,

  // Execution unit
  output logic                  eu_valid_o,
  input  logic                  eu_ready_i,
  output expipe_pkg::eu_req_t   eu_req_o,
  input  logic                  eu_valid_i,
  input  expipe_pkg::eu_res_t   eu_res_i,

  // CDB
  input  logic                  cdb_valid_i,
  input  expipe_pkg::cdb_data_t cdb_data_i,
  output logic                  cdb_valid_o,
  input  logic                  cdb_ready_i,
  output expipe_pkg::cdb_data_t cdb_data_o
);

  import arith_rs_pkg::*;

  logic      [`ARITH_RS_DEPTH-1:0] empty;
  logic      [`ARITH_RS_DEPTH-1:0] ex_req;
  logic      [`ARITH_RS_DEPTH-1:0] cdb_req;
  logic      [`ARITH_RS_DEPTH-1:0] insert;
  logic      [`ARITH_RS_DEPTH-1:0] ex_grant;
  logic      [`ARITH_RS_DEPTH-1:0] cdb_grant;
  rs_entry_t [`ARITH_RS_DEPTH-1:0] entries;

  // ------------------------------------------------
  // Entries
  // ------------------------------------------------
  for (genvar i = 0; i < `ARITH_RS_DEPTH; i++) begin : gen_entries
    arith_rs_entry i_entry (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .insert_i   (insert[i]),
      .ex_grant_i (ex_grant[i]),
      .cdb_grant_i(cdb_grant[i]),
      .issue_req_i(issue_req_i),
      .eu_valid_i (eu_valid_i),
      .eu_res_i   (eu_res_i),
      .cdb_valid_i(cdb_valid_i),
      .cdb_data_i (cdb_data_i),
      .empty_o    (empty[i]),
      .ex_req_o   (ex_req[i]),
      .cdb_req_o  (cdb_req[i]),
      .entry_o    (entries[i])
    );
  end

  // Pointer, arbitration and output muxes
  arith_rs_select i_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .issue_valid_i(issue_valid_i),
    .issue_ready_o(issue_ready_o),
    .empty_i      (empty),
    .ex_req_i     (ex_req),
    .cdb_req_i    (cdb_req),
    .entries_i    (entries),
    .eu_ready_i   (eu_ready_i),
    .eu_valid_o   (eu_valid_o),
    .eu_req_o     (eu_req_o),
    .cdb_ready_i  (cdb_ready_i),
    .cdb_valid_o  (cdb_valid_o),
    .cdb_data_o   (cdb_data_o),
    .insert_o     (insert),
    .ex_grant_o   (ex_grant),
    .cdb_grant_o  (cdb_grant)
  );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD = 20;  // 40 ns clock
  localparam int RST_CYCLES  = 8;

  initial begin : p_clk
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin : p_rst
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;  // Released on an edge, like the stimulus
  end

endmodule

`default_nettype wire

/* tests/arith_rs_props.sv */
// Reservation station assertions

`timescale 1ns/1ps
`include "arith_rs_cfg.svh"
`default_nettype none

module arith_rs_props (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        flush_i,
  input logic                        eu_valid_o,
  input logic                        eu_ready_i,
  input expipe_pkg::eu_req_t         eu_req_o,
  input logic                        cdb_valid_o,
  input logic                        cdb_ready_i,
  input expipe_pkg::cdb_data_t       cdb_data_o,
  input logic  [`ARITH_RS_DEPTH-1:0] ex_req_i,
  input logic  [`ARITH_RS_DEPTH-1:0] cdb_req_i,
  input logic  [`ARITH_RS_DEPTH-1:0] insert_i,
  input logic  [`ARITH_RS_DEPTH-1:0] ex_grant_i,
  input logic  [`ARITH_RS_DEPTH-1:0] cdb_grant_i
);

  int fail_count;  // Assertion failures so far

  // A lower entry joining the request set may take over the output
  a_eu_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    eu_valid_o && !eu_ready_i && !flush_i |=>
      eu_valid_o && ($stable(eu_req_o) || !$stable(ex_req_i)))
    else begin
      fail_count++;
      $error("EU request dropped or changed while stalled");
    end

  a_cdb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cdb_valid_o && !cdb_ready_i && !flush_i |=>
      cdb_valid_o && ($stable(cdb_data_o) || !$stable(cdb_req_i)))
    else begin
      fail_count++;
      $error("CDB data dropped or changed while stalled");
    end

  // Grants go only to entries that request
  a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(insert_i) && $onehot0(ex_grant_i) && $onehot0(cdb_grant_i) &&
    ((ex_grant_i & ~ex_req_i) == '0) && ((cdb_grant_i & ~cdb_req_i) == '0))
    else begin
      fail_count++;
      $error("Entry strobes not one-hot or granted without a request");
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !eu_valid_o && !cdb_valid_o)
    else begin
      fail_count++;
      $error("Valid output high right after flush");
    end

endmodule

bind arith_rs arith_rs_props i_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .flush_i    (flush_i),
  .eu_valid_o (eu_valid_o),
  .eu_ready_i (eu_ready_i),
  .eu_req_o   (eu_req_o),
  .cdb_valid_o(cdb_valid_o),
  .cdb_ready_i(cdb_ready_i),
  .cdb_data_o (cdb_data_o),
  .ex_req_i   (ex_req),
  .cdb_req_i  (cdb_req),
  .insert_i   (insert),
  .ex_grant_i (ex_grant),
  .cdb_grant_i(cdb_grant)
);

`default_nettype wire

/* tests/tb_arith_rs.sv */
// Reservation station testbench

`timescale 1ns/1ps
`include "arith_rs_cfg.svh"
`default_nettype none

module tb_arith_rs;

  import expipe_pkg::*;

  localparam int NUM_INSTR  = 400;
  localparam int MAX_CYCLES = NUM_INSTR * 40;
  localparam int NTAGS      = 1 << `ROB_IDX_LEN;
  localparam int DEPTH      = `ARITH_RS_DEPTH;

  logic       clk_i, rst_ni, flush_i;
  logic       issue_valid_i, issue_ready_o;
  issue_req_t issue_req_i;
  logic       eu_valid_o, eu_ready_i, eu_valid_i;
  eu_req_t    eu_req_o;
  eu_res_t    eu_res_i;
  logic       cdb_valid_i, cdb_valid_o, cdb_ready_i;
  cdb_data_t  cdb_data_i, cdb_data_o;

  // Reference model, indexed by ROB entry
  word_t   tag_val [NTAGS];  // True value of the ROB entry
  word_t   tag_a [NTAGS];
  word_t   tag_b [NTAGS];
  eu_ctl_t tag_ctl [NTAGS];
  bit      owned [NTAGS];     // Issued, not yet on the CDB
  bit      ext_pend [NTAGS];  // Other unit still has to broadcast
  bit      bcast [NTAGS];     // Value already seen on a bus
  bit      eu_taken [NTAGS];
  int      ext_due [NTAGS];
  int      eu_tag_q[$];       // Behavioral EU results in flight
  int      eu_due_q[$];
  word_t   eu_val_q[$];

  issue_req_t pend;  // Instruction offered to the station
  bit pend_v, active, gen_en, hold_cdb, flush_req, flushed;
  int cyc, flush_chk, n_issued, n_done, occupancy, errors;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  arith_rs i_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .issue_valid_i(issue_valid_i), .issue_ready_o(issue_ready_o), .issue_req_i(issue_req_i),
    .eu_valid_o(eu_valid_o), .eu_ready_i(eu_ready_i), .eu_req_o(eu_req_o),
    .eu_valid_i(eu_valid_i), .eu_res_i(eu_res_i),
    .cdb_valid_i(cdb_valid_i), .cdb_data_i(cdb_data_i),
    .cdb_valid_o(cdb_valid_o), .cdb_ready_i(cdb_ready_i), .cdb_data_o(cdb_data_o)
  );

  // Sum for even codes, exclusive-or for odd ones
  function automatic word_t eu_func(input eu_ctl_t ctl, input word_t a, input word_t b);
    return ctl[0] ? (a ^ b) : (a + b);
  endfunction

  task automatic check_eq(input string what, input logic [`XLEN-1:0] got,
                          input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic int free_tag();
    int start;
    int t;
    start = int'($urandom % NTAGS);
    for (int i = 0; i < NTAGS; i++) begin
      t = (start + i) % NTAGS;
      if (!owned[t] && !ext_pend[t]) return t;
    end
    return -1;
  endfunction

  // Any producer whose value has not been broadcast yet
  function automatic int pick_producer(input int dest);
    int start;
    int t;
    start = int'($urandom % NTAGS);
    for (int i = 0; i < NTAGS; i++) begin
      t = (start + i) % NTAGS;
      if ((owned[t] || ext_pend[t]) && !bcast[t] && t != dest) return t;
    end
    return -1;
  endfunction

  task automatic make_operand(input int dest, output op_data_t op, output word_t v);
    int kind;
    int t;
    kind       = int'($urandom % 4);
    t          = -1;
    op.ready   = 1'b1;
    op.rob_idx = rob_idx_t'($urandom);
    op.value   = {$urandom, $urandom};
    v          = op.value;
    if (kind == 1) begin  // New value from another unit
      t = free_tag();
      if (t >= 0) begin
        ext_pend[t] = 1;
        bcast[t]    = 0;
        tag_val[t]  = {$urandom, $urandom};
        ext_due[t]  = cyc + int'($urandom % 8);
      end
    end else if (kind >= 2) begin
      t = pick_producer(dest);
    end
    if (t >= 0) begin
      op.ready   = 1'b0;
      op.rob_idx = rob_idx_t'(t);
      v          = tag_val[t];
    end
  endtask

  task automatic make_issue();
    int    d;
    word_t a;
    word_t b;
    d = free_tag();
    if (d >= 0) begin
      owned[d]    = 1;
      bcast[d]    = 0;
      eu_taken[d] = 0;
      make_operand(d, pend.rs1, a);
      make_operand(d, pend.rs2, b);
      pend.eu_ctl       = eu_ctl_t'($urandom);
      pend.dest_rob_idx = rob_idx_t'(d);
      tag_ctl[d] = pend.eu_ctl;
      tag_a[d]   = a;
      tag_b[d]   = b;
      tag_val[d] = eu_func(pend.eu_ctl, a, b);
      pend_v     = 1;
    end
  endtask

  // Issue logic reads values already broadcast from the ROB
  task automatic convert_pending();
    if (pend_v && !pend.rs1.ready && bcast[pend.rs1.rob_idx]) begin
      pend.rs1.ready = 1'b1;
      pend.rs1.value = tag_val[pend.rs1.rob_idx];
    end
    if (pend_v && !pend.rs2.ready && bcast[pend.rs2.rob_idx]) begin
      pend.rs2.ready = 1'b1;
      pend.rs2.value = tag_val[pend.rs2.rob_idx];
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < NTAGS; i++) begin
      owned[i]    = 0;
      ext_pend[i] = 0;
      bcast[i]    = 0;
      eu_taken[i] = 0;
    end
    eu_tag_q.delete();
    eu_due_q.delete();
    eu_val_q.delete();
    pend_v    = 0;
    occupancy = 0;
  endtask

  // Transfers of the cycle that just ended
  task automatic observe();
    int t;
    if (issue_valid_i && issue_ready_o) begin
      pend_v = 0;
      occupancy++;
      n_issued++;
    end
    if (eu_valid_o && eu_ready_i) begin
      t = int'(eu_req_o.rob_idx);
      check_eq("EU request tag outstanding", owned[t] && !eu_taken[t], 1);
      check_eq("EU control", eu_req_o.eu_ctl, tag_ctl[t]);
      check_eq("EU rs1 value", eu_req_o.rs1_value, tag_a[t]);
      check_eq("EU rs2 value", eu_req_o.rs2_value, tag_b[t]);
      eu_taken[t] = 1;
      eu_tag_q.push_back(t);
      eu_due_q.push_back(cyc + int'($urandom % 6));
      eu_val_q.push_back(eu_func(eu_req_o.eu_ctl, eu_req_o.rs1_value, eu_req_o.rs2_value));
    end
    if (cdb_valid_o && cdb_ready_i) begin
      t = int'(cdb_data_o.rob_idx);
      check_eq("CDB tag outstanding", owned[t] && eu_taken[t], 1);
      check_eq("CDB result", cdb_data_o.res_value, tag_val[t]);
      owned[t] = 0;
      occupancy--;
      n_done++;
    end
  endtask

  task automatic drive_buses();
    int    t;
    word_t r;
    t = -1;
    eu_valid_i  <= 1'b0;
    eu_res_i    <= '0;
    cdb_valid_i <= 1'b0;
    cdb_data_i  <= '0;
    if (eu_tag_q.size() > 0 && eu_due_q[0] <= cyc) begin
      t = eu_tag_q.pop_front();
      r = eu_val_q.pop_front();
      void'(eu_due_q.pop_front());
      eu_valid_i <= 1'b1;
      eu_res_i   <= '{rob_idx: rob_idx_t'(t), result: r};
      bcast[t]    = 1;
    end
    t = -1;
    for (int i = 0; i < NTAGS; i++) begin
      if (t < 0 && ext_pend[i] && ext_due[i] <= cyc) t = i;
    end
    if (t >= 0) begin  // Other unit broadcasts
      cdb_valid_i <= 1'b1;
      cdb_data_i  <= '{rob_idx: rob_idx_t'(t), res_value: tag_val[t]};
      ext_pend[t]  = 0;
      bcast[t]     = 1;
    end
  endtask

  task automatic end_run();
    errors += i_dut.i_props.fail_count;
    $display("Run finished: %0d errors, %0d issued, %0d written to the CDB",
             errors, n_issued, n_done);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  // --------------------------------------------------
  // Per-cycle stimulus and model update
  // --------------------------------------------------
  always @(posedge clk_i) begin : p_step
    if (active) begin
      cyc++;
      if (cyc > MAX_CYCLES) begin
        $display("Timeout: no progress within %0d cycles", MAX_CYCLES);
        errors++;
        end_run();
      end else begin
        if (flush_chk == 1) begin
          check_eq("eu_valid_o after flush", eu_valid_o, 0);
          check_eq("cdb_valid_o after flush", cdb_valid_o, 0);
          check_eq("issue_ready_o after flush", issue_ready_o, 1);
        end
        if (flush_chk > 0) flush_chk--;
        if (!flushed) observe();
        flushed  = 0;
        flush_i <= 1'b0;
        if (flush_req) begin
          flush_req = 0;
          flushed   = 1;
          flush_chk = 2;
          clear_model();
          flush_i       <= 1'b1;
          issue_valid_i <= 1'b0;
          eu_valid_i    <= 1'b0;
          cdb_valid_i   <= 1'b0;
        end else begin
          if (gen_en && !pend_v && ($urandom % 4 != 0)) make_issue();
          convert_pending();
          drive_buses();
          issue_valid_i <= gen_en && pend_v;
          issue_req_i   <= pend;
        end
        eu_ready_i  <= ($urandom % 4) != 0;
        cdb_ready_i <= !hold_cdb && (($urandom % 4) != 0);
      end
    end
  end

  task automatic wait_issued(input int n);
    while (n_issued < n) @(negedge clk_i);
  endtask

  task automatic request_flush();
    @(negedge clk_i);
    flush_req = 1;
    @(negedge clk_i);
  endtask

  initial begin : p_main
    void'($urandom(32'hd527c9a6));
    flush_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    eu_ready_i    = 1'b0;
    eu_valid_i    = 1'b0;
    eu_res_i      = '0;
    cdb_valid_i   = 1'b0;
    cdb_data_i    = '0;
    cdb_ready_i   = 1'b0;
    pend          = '0;
    clear_model();
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    active = 1;
    gen_en = 1;
    // Random traffic with two flushes on the way
    wait_issued(NUM_INSTR / 3);
    request_flush();
    wait_issued(2 * NUM_INSTR / 3);
    request_flush();
    wait_issued(NUM_INSTR);
    gen_en = 0;
    while (occupancy != 0) @(negedge clk_i);
    // Fill every entry with the CDB blocked
    request_flush();
    repeat (3) @(negedge clk_i);
    hold_cdb = 1;
    gen_en   = 1;
    while (occupancy < DEPTH) @(negedge clk_i);
    gen_en = 0;
    @(negedge clk_i);
    check_eq("issue_ready_o with all entries full", issue_ready_o, 0);
    hold_cdb = 0;
    while (!issue_ready_o) @(negedge clk_i);
    while (occupancy != 0) @(negedge clk_i);
    end_run();
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/expipe_pkg.sv
rtl/arith_rs_pkg.sv
rtl/arith_rs_entry.sv
rtl/arith_rs_select.sv
rtl/arith_rs.sv
tests/tb_clk_gen.sv
tests/arith_rs_props.sv
tests/tb_arith_rs.sv

/* Makefile */
# Verilator build and run of the reservation station testbench

TOP := tb_arith_rs

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) --Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
